//--- Makefile
SOURCES := $(filter-out +%,$(shell cat flist.f))
SIM     := obj_dir/Vpvr_regs_tb

.PHONY: all run clean

all: run

$(SIM): flist.f $(SOURCES)
	verilator --binary --timing --assert --top-module pvr_regs_tb -f flist.f

run: $(SIM)
	./$(SIM) +verilator+error+limit+1000 > sim.log 2>&1 || (cat sim.log && false)
	cat sim.log
	! grep -q "Simulation finished: FAIL" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bench/pvr_regs_assertions.sv
`timescale 1ns/1ps

module pvr_regs_assertions
	import pvr_pkg::*;
(
	input logic      clock,
	input logic      reset_n,
	input logic      pvr_reg_cs_i,
	input logic      pvr_rd_i,
	input logic      pvr_wr_i,
	input reg_word_t pvr_dout_o,
	input reg_word_t param_base_o,
	input reg_word_t region_base_o,
	input reg_word_t fpu_param_cfg_o,
	input reg_word_t ta_alloc_ctrl_o
);

	int unsigned fail_count = 0;                        // picked up by the testbench at the end

	wire cs_wr = pvr_reg_cs_i & pvr_wr_i;               // write that reaches the bank
	wire cs_rd = pvr_reg_cs_i & pvr_rd_i;               // read that reaches the mux
	wire [127:0] cfg_all = {param_base_o, region_base_o, fpu_param_cfg_o, ta_alloc_ctrl_o};

	// host never overlaps the two strobes
	rd_wr_exclusive: assert property (@(posedge clock) disable iff (!reset_n)
		!(pvr_rd_i && pvr_wr_i))
		else begin
			fail_count++;
			$error("read and write strobes high in the same cycle");
		end

	cfg_after_write: assert property (@(posedge clock) disable iff (!reset_n)
		$changed(cfg_all) |-> $past(cs_wr))             // outputs move only after a write
		else begin
			fail_count++;
			$error("configuration output changed without a chip-selected write");
		end

	dout_after_read: assert property (@(posedge clock) disable iff (!reset_n)
		$changed(pvr_dout_o) |-> $past(cs_rd))          // dout holds between reads
		else begin
			fail_count++;
			$error("pvr_dout_o changed without a chip-selected read");
		end

endmodule

bind pvr_regs pvr_regs_assertions u_assertions (
	.clock           (clock),
	.reset_n         (reset_n),
	.pvr_reg_cs_i    (pvr_reg_cs_i),
	.pvr_rd_i        (pvr_rd_i),
	.pvr_wr_i        (pvr_wr_i),
	.pvr_dout_o      (pvr_dout_o),
	.param_base_o    (param_base_o),
	.region_base_o   (region_base_o),
	.fpu_param_cfg_o (fpu_param_cfg_o),
	.ta_alloc_ctrl_o (ta_alloc_ctrl_o)
);

//--- bench/pvr_regs_tb.sv
`timescale 1ns/1ps

module pvr_regs_tb
	import pvr_pkg::*;
();

	localparam int CLK_PERIOD   = 4;
	localparam int RESET_CYCLES = 8;
	localparam int N_REG_OPS    = 150;                  // write/read pairs on the rw registers
	localparam int N_UNMAPPED   = 20;
	localparam int N_PAL_OPS    = 128;
	localparam int N_NOCS       = 20;                   // rounds with the chip select low
	localparam int N_ACCESSES   = 16 + 2 * N_REG_OPS + 18 + 3 * N_UNMAPPED
	                            + 2 * N_PAL_OPS + 4 * N_NOCS;
	localparam int WATCHDOG_CYCLES = N_ACCESSES * 4 + RESET_CYCLES + 200;

	logic       clock;
	logic       reset_n;
	logic       pvr_reg_cs_i;
	host_addr_t pvr_addr_i;
	reg_word_t  pvr_din_i;
	logic       pvr_rd_i;
	logic       pvr_wr_i;
	reg_word_t  pvr_dout_o;
	reg_word_t  param_base_o;
	reg_word_t  region_base_o;
	reg_word_t  fpu_param_cfg_o;
	reg_word_t  ta_alloc_ctrl_o;

	host_addr_t reg_addr [16];                          // offsets in select order
	reg_word_t  reg_model [16];                         // expected register contents
	reg_word_t  pal_model [int];                        // expected palette, keyed by index
	host_addr_t pal_written [$];                        // palette addresses with known data
	int         pal_depth;
	integer     seed;
	int         checks;
	int         errors;

	pvr_regs u_pvr_regs (
		.clock           (clock),
		.reset_n         (reset_n),
		.pvr_reg_cs_i    (pvr_reg_cs_i),
		.pvr_addr_i      (pvr_addr_i),
		.pvr_din_i       (pvr_din_i),
		.pvr_rd_i        (pvr_rd_i),
		.pvr_wr_i        (pvr_wr_i),
		.pvr_dout_o      (pvr_dout_o),
		.param_base_o    (param_base_o),
		.region_base_o   (region_base_o),
		.fpu_param_cfg_o (fpu_param_cfg_o),
		.ta_alloc_ctrl_o (ta_alloc_ctrl_o)
	);

	always #(CLK_PERIOD / 2) clock = ~clock;

	function automatic int reg_index(input host_addr_t addr);
		for (int i = 0; i < 16; i++) begin
			if (reg_addr[i] == addr) begin
				return i;
			end
		end
		return -1;                                      // not a kept register
	endfunction

	function automatic bit in_palette(input host_addr_t addr);
		return (addr >= PAL_BASE_ADDR) && (addr <= 16'h1FFF);
	endfunction

	function automatic int pal_slot(input host_addr_t addr);
		return (int'(addr) >> 2) % pal_depth;           // word address, wraps on a short index
	endfunction

	function automatic reg_word_t expected_read(input host_addr_t addr);
		int idx;
		idx = reg_index(addr);
		if (in_palette(addr)) begin
			return pal_model[pal_slot(addr)];
		end
		if (idx >= 0) begin
			return reg_model[idx];
		end
		return '0;                                      // unmapped reads zero
	endfunction

	task automatic model_write(input host_addr_t addr, input reg_word_t data);
		int idx;
		idx = reg_index(addr);
		if (in_palette(addr)) begin
			pal_model[pal_slot(addr)] = data;
		end else if (idx >= 2) begin
			reg_model[idx] = data;                      // id and revision stay fixed
		end
	endtask

	task automatic compare_word(input string name, input reg_word_t expected,
	                            input reg_word_t actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("[ERROR] %0t %s expected %08h actual %08h", $time, name, expected, actual);
		end
	endtask

	task automatic bus_write(input host_addr_t addr, input reg_word_t data, input logic cs);
		@(negedge clock);
		pvr_reg_cs_i = cs;
		pvr_addr_i   = addr;
		pvr_din_i    = data;
		pvr_wr_i     = 1'b1;
		@(negedge clock);                               // sampled at the rising edge between
		pvr_wr_i     = 1'b0;
		pvr_reg_cs_i = 1'b0;
	endtask

	task automatic bus_read(input host_addr_t addr, input logic cs, output reg_word_t data);
		@(negedge clock);
		pvr_reg_cs_i = cs;
		pvr_addr_i   = addr;
		pvr_rd_i     = 1'b1;
		@(negedge clock);
		pvr_rd_i     = 1'b0;
		pvr_reg_cs_i = 1'b0;
		data = pvr_dout_o;                              // valid half a cycle after the read edge
	endtask

	task automatic check_config();
		compare_word("param_base_o", reg_model[4], param_base_o);
		compare_word("region_base_o", reg_model[5], region_base_o);
		compare_word("fpu_param_cfg_o", reg_model[10], fpu_param_cfg_o);
		compare_word("ta_alloc_ctrl_o", reg_model[15], ta_alloc_ctrl_o);
	endtask

	task automatic verify_regs();
		reg_word_t data;
		for (int i = 0; i < 16; i++) begin
			bus_read(reg_addr[i], 1'b1, data);
			compare_word($sformatf("pvr_dout_o[%04h]", reg_addr[i]), reg_model[i], data);
		end
		check_config();
	endtask

	task automatic random_unmapped(output host_addr_t addr);
		do begin
			addr = host_addr_t'($random(seed));
		end while (reg_index(addr) >= 0 || in_palette(addr));
	endtask

	task automatic report_test(input string name, input int errors_before);
		$display("test %s done: %0d mismatches", name, errors - errors_before);
	endtask

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: the accesses did not complete within %0d cycles", WATCHDOG_CYCLES);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		reg_word_t  data;
		reg_word_t  prev;
		host_addr_t addr;
		int         idx;
		int         mark;
		int         assert_fails;
		$timeformat(-9, 0, " ns", 0);
		seed         = 32'h56e6_3b87;
		checks       = 0;
		errors       = 0;
		clock        = 1'b0;
		reset_n      = 1'b0;
		pvr_reg_cs_i = 1'b0;
		pvr_addr_i   = '0;
		pvr_din_i    = '0;
		pvr_rd_i     = 1'b0;
		pvr_wr_i     = 1'b0;
		pal_depth    = 1 << u_pvr_regs.PAL_ADDR_W;
		reg_addr     = '{ID_ADDR, REVISION_ADDR, SOFTRESET_ADDR, STARTRENDER_ADDR,
		                 PARAM_BASE_ADDR, REGION_BASE_ADDR, FB_R_CTRL_ADDR, FB_W_CTRL_ADDR,
		                 FB_R_SIZE_ADDR, FB_W_SOF1_ADDR, FPU_PARAM_CFG_ADDR, ISP_BACKGND_D_ADDR,
		                 SPG_CONTROL_ADDR, VO_CONTROL_ADDR, TA_ISP_BASE_ADDR, TA_ALLOC_CTRL_ADDR};
		foreach (reg_model[i]) begin
			reg_model[i] = '0;
		end
		reg_model[0] = PVR_ID_VALUE;
		reg_model[1] = PVR_REVISION_VALUE;
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		reset_n = 1'b1;

		mark = errors;
		compare_word("pvr_dout_o", '0, pvr_dout_o);     // read data cleared by reset
		verify_regs();                                  // constants, zeros, config outputs
		report_test("reset state", mark);

		mark = errors;
		for (int n = 0; n < N_REG_OPS; n++) begin
			idx  = 2 + ($unsigned($random(seed)) % 14);
			data = $random(seed);
			bus_write(reg_addr[idx], data, 1'b1);
			model_write(reg_addr[idx], data);
			check_config();
			idx = $unsigned($random(seed)) % 16;
			bus_read(reg_addr[idx], 1'b1, data);
			compare_word("pvr_dout_o", expected_read(reg_addr[idx]), data);
		end
		report_test("random register access", mark);

		mark = errors;
		bus_write(ID_ADDR, $random(seed), 1'b1);        // read-only, must be dropped
		bus_write(REVISION_ADDR, $random(seed), 1'b1);
		for (int n = 0; n < N_UNMAPPED; n++) begin
			random_unmapped(addr);
			bus_write(addr, $random(seed), 1'b1);
			bus_read(ID_ADDR, 1'b1, data);              // leave a nonzero word on the bus
			compare_word("pvr_dout_o", expected_read(ID_ADDR), data);
			bus_read(addr, 1'b1, data);
			compare_word($sformatf("pvr_dout_o[%04h]", addr), expected_read(addr), data);
		end
		verify_regs();
		report_test("read-only and unmapped", mark);

		mark = errors;
		for (int n = 0; n < N_PAL_OPS; n++) begin
			addr = PAL_BASE_ADDR | (host_addr_t'($random(seed)) & 16'h0FFC);
			data = $random(seed);
			bus_write(addr, data, 1'b1);
			model_write(addr, data);
			pal_written.push_back(addr);
		end
		for (int n = 0; n < N_PAL_OPS; n++) begin
			addr = pal_written[$unsigned($random(seed)) % pal_written.size()];
			bus_read(addr, 1'b1, data);
			compare_word($sformatf("pvr_dout_o[%04h]", addr), expected_read(addr), data);
		end
		report_test("palette window", mark);

		mark = errors;
		for (int n = 0; n < N_NOCS; n++) begin
			if (n % 2 == 0) begin
				addr = reg_addr[2 + ($unsigned($random(seed)) % 14)];
			end else begin
				addr = pal_written[$unsigned($random(seed)) % pal_written.size()];
			end
			bus_read(addr, 1'b1, data);
			compare_word("pvr_dout_o", expected_read(addr), data);
			prev = data;
			bus_write(addr, ~data, 1'b0);               // would land if cs were ignored
			bus_read(reg_addr[$unsigned($random(seed)) % 16], 1'b0, data);
			compare_word("pvr_dout_o held", prev, data);
			bus_read(addr, 1'b1, data);
			compare_word("pvr_dout_o", expected_read(addr), data);
		end
		check_config();
		report_test("chip select low", mark);

		assert_fails = u_pvr_regs.u_assertions.fail_count;
		$display("checks %0d, mismatches %0d, assertion failures %0d",
		         checks, errors, assert_fails);
		if (errors == 0 && assert_fails == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

//--- flist.f
logic/pvr_pkg.sv
logic/reg_access_if.sv
logic/pvr_addr_decode.sv
logic/pvr_reg_bank.sv
logic/pvr_palette_ram.sv
logic/pvr_read_mux.sv
logic/pvr_regs.sv
bench/pvr_regs_assertions.sv
bench/pvr_regs_tb.sv

//--- logic/pvr_addr_decode.sv
`timescale 1ns/1ps

module pvr_addr_decode
	import pvr_pkg::*;
#(
	parameter int PAL_ADDR_W = 10                       // palette index width
) (
	input  logic       reg_cs_i,                        // register space chip select
	input  host_addr_t addr_i,                          // host byte address
	input  reg_word_t  din_i,                           // host write data
	input  logic       rd_i,                            // host read strobe
	input  logic       wr_i,                            // host write strobe
	reg_access_if.decode acc                            // decoded access out
);

	// strobes only count with the chip select up
	assign acc.wr_en = reg_cs_i & wr_i;
	assign acc.rd_en = reg_cs_i & rd_i;
	assign acc.wdata = din_i;

	// window is the 4k page at PAL_BASE_ADDR, low byte bits ignored
	assign acc.pal_hit = (addr_i[15:12] == PAL_BASE_ADDR[15:12]);

	// word address, a narrower index simply aliases over the window
	assign acc.pal_index = addr_i[PAL_ADDR_W+1:2];

	// exact offset match, byte lanes other than 0 are unmapped
	always_comb begin
		case (addr_i)
			ID_ADDR:            acc.sel = REG_ID;
			REVISION_ADDR:      acc.sel = REG_REVISION;
			SOFTRESET_ADDR:     acc.sel = REG_SOFTRESET;
			STARTRENDER_ADDR:   acc.sel = REG_STARTRENDER;
			PARAM_BASE_ADDR:    acc.sel = REG_PARAM_BASE;
			REGION_BASE_ADDR:   acc.sel = REG_REGION_BASE;
			FB_R_CTRL_ADDR:     acc.sel = REG_FB_R_CTRL;
			FB_W_CTRL_ADDR:     acc.sel = REG_FB_W_CTRL;
			FB_R_SIZE_ADDR:     acc.sel = REG_FB_R_SIZE;
			FB_W_SOF1_ADDR:     acc.sel = REG_FB_W_SOF1;
			FPU_PARAM_CFG_ADDR: acc.sel = REG_FPU_PARAM_CFG;
			ISP_BACKGND_D_ADDR: acc.sel = REG_ISP_BACKGND_D;
			SPG_CONTROL_ADDR:   acc.sel = REG_SPG_CONTROL;
			VO_CONTROL_ADDR:    acc.sel = REG_VO_CONTROL;
			TA_ISP_BASE_ADDR:   acc.sel = REG_TA_ISP_BASE;
			TA_ALLOC_CTRL_ADDR: acc.sel = REG_TA_ALLOC_CTRL;
			default:            acc.sel = REG_NONE;     // includes the palette window
		endcase
	end

endmodule

//--- logic/pvr_palette_ram.sv
`timescale 1ns/1ps

module pvr_palette_ram
	import pvr_pkg::*;
#(
	parameter int PAL_ADDR_W = 10                       // 2**PAL_ADDR_W palette words
) (
	input  logic          clock,
	reg_access_if.palette acc,                          // decoded palette access
	output reg_word_t     rdata_o                       // registered read word
);

	localparam int PAL_DEPTH = 2 ** PAL_ADDR_W;

	reg_word_t mem [PAL_DEPTH];                         // palette entries
	reg_word_t rdata_q;                                 // last word read out

	wire wr_hit = acc.wr_en & acc.pal_hit;              // cs already folded into wr_en
	wire rd_hit = acc.rd_en & acc.pal_hit;

	always_ff @(posedge clock) begin
		if (wr_hit) begin
			mem[acc.pal_index] <= acc.wdata;
		end
		if (rd_hit) begin
			rdata_q <= mem[acc.pal_index];              // held until the next palette read
		end
	end

	assign rdata_o = rdata_q;

endmodule

//--- logic/pvr_pkg.sv
package pvr_pkg;

	typedef logic [15:0] host_addr_t;                   // host byte address
	typedef logic [31:0] reg_word_t;                    // register / palette data word

	// one select per kept register, REG_NONE for anything unmapped
	typedef enum logic [4:0] {
		REG_ID,                                         // read only
		REG_REVISION,                                   // read only
		REG_SOFTRESET,
		REG_STARTRENDER,
		REG_PARAM_BASE,
		REG_REGION_BASE,
		REG_FB_R_CTRL,
		REG_FB_W_CTRL,
		REG_FB_R_SIZE,
		REG_FB_W_SOF1,
		REG_FPU_PARAM_CFG,
		REG_ISP_BACKGND_D,
		REG_SPG_CONTROL,
		REG_VO_CONTROL,
		REG_TA_ISP_BASE,
		REG_TA_ALLOC_CTRL,
		REG_NONE                                        // unmapped, reads zero
	} reg_sel_e;

	// register byte offsets on the host bus
	localparam host_addr_t ID_ADDR            = 16'h0000; // device id
	localparam host_addr_t REVISION_ADDR      = 16'h0004; // revision number
	localparam host_addr_t SOFTRESET_ADDR     = 16'h0008; // core and ta soft reset
	localparam host_addr_t STARTRENDER_ADDR   = 16'h0014; // drawing start
	localparam host_addr_t PARAM_BASE_ADDR    = 16'h0020; // isp parameter base
	localparam host_addr_t REGION_BASE_ADDR   = 16'h002C; // region array base
	localparam host_addr_t FB_R_CTRL_ADDR     = 16'h0044; // fb read control
	localparam host_addr_t FB_W_CTRL_ADDR     = 16'h0048; // fb write control
	localparam host_addr_t FB_R_SIZE_ADDR     = 16'h005C; // fb xy size
	localparam host_addr_t FB_W_SOF1_ADDR     = 16'h0060; // fb write start, field 1
	localparam host_addr_t FPU_PARAM_CFG_ADDR = 16'h007C; // parameter read control
	localparam host_addr_t ISP_BACKGND_D_ADDR = 16'h0088; // background depth
	localparam host_addr_t SPG_CONTROL_ADDR   = 16'h00D0; // sync pulse generator
	localparam host_addr_t VO_CONTROL_ADDR    = 16'h00E8; // video output control
	localparam host_addr_t TA_ISP_BASE_ADDR   = 16'h0128; // ta isp/tsp write base
	localparam host_addr_t TA_ALLOC_CTRL_ADDR = 16'h0140; // object list control

	// palette window spans 1000..1FFC, one 32-bit entry per word
	localparam host_addr_t PAL_BASE_ADDR = 16'h1000;

	// fixed values of the read-only registers
	localparam reg_word_t PVR_ID_VALUE       = 32'h17FD_11DB;
	localparam reg_word_t PVR_REVISION_VALUE = 32'h0000_0011;

endpackage

//--- logic/pvr_read_mux.sv
`timescale 1ns/1ps

module pvr_read_mux
	import pvr_pkg::*;
(
	input  logic         clock,
	input  logic         reset_n,
	reg_access_if.result acc,                           // read strobe and palette flag
	input  reg_word_t    reg_rdata_i,                   // combinational register word
	input  reg_word_t    pal_rdata_i,                   // palette word, already registered
	output reg_word_t    dout_o                         // host read data
);

	reg_word_t reg_rdata_q;                             // register word of the last read
	logic      pal_sel_q;                               // last read went to the palette

	// both sources are sampled on the same read edge
	always_ff @(posedge clock or negedge reset_n) begin
		if (!reset_n) begin
			reg_rdata_q <= '0;
			pal_sel_q   <= 1'b0;
		end else if (acc.rd_en) begin
			reg_rdata_q <= reg_rdata_i;
			pal_sel_q   <= acc.pal_hit;
		end
	end

	// palette word only moves on a palette read, so dout holds between reads
	assign dout_o = pal_sel_q ? pal_rdata_i : reg_rdata_q;

endmodule

//--- logic/pvr_reg_bank.sv
`timescale 1ns/1ps

module pvr_reg_bank
	import pvr_pkg::*;
(
	input  logic       clock,
	input  logic       reset_n,
	reg_access_if.bank acc,                             // decoded write path
	output reg_word_t  rdata_o,                         // word of the selected register
	output reg_word_t  param_base_o,                    // to region-array parser
	output reg_word_t  region_base_o,
	output reg_word_t  fpu_param_cfg_o,
	output reg_word_t  ta_alloc_ctrl_o
);

	reg_word_t softreset_q;                             // core and ta soft reset
	reg_word_t startrender_q;                           // drawing start
	reg_word_t param_base_q;
	reg_word_t region_base_q;
	reg_word_t fb_r_ctrl_q;
	reg_word_t fb_w_ctrl_q;
	reg_word_t fb_r_size_q;
	reg_word_t fb_w_sof1_q;
	reg_word_t fpu_param_cfg_q;
	reg_word_t isp_backgnd_d_q;
	reg_word_t spg_control_q;
	reg_word_t vo_control_q;
	reg_word_t ta_isp_base_q;
	reg_word_t ta_alloc_ctrl_q;

	always_ff @(posedge clock or negedge reset_n) begin
		if (!reset_n) begin
			softreset_q     <= '0;
			startrender_q   <= '0;
			param_base_q    <= '0;
			region_base_q   <= '0;
			fb_r_ctrl_q     <= '0;
			fb_w_ctrl_q     <= '0;
			fb_r_size_q     <= '0;
			fb_w_sof1_q     <= '0;
			fpu_param_cfg_q <= '0;
			isp_backgnd_d_q <= '0;
			spg_control_q   <= '0;
			vo_control_q    <= '0;
			ta_isp_base_q   <= '0;
			ta_alloc_ctrl_q <= '0;
		end else if (acc.wr_en) begin
			case (acc.sel)
				REG_SOFTRESET:     softreset_q     <= acc.wdata;
				REG_STARTRENDER:   startrender_q   <= acc.wdata;
				REG_PARAM_BASE:    param_base_q    <= acc.wdata;
				REG_REGION_BASE:   region_base_q   <= acc.wdata;
				REG_FB_R_CTRL:     fb_r_ctrl_q     <= acc.wdata;
				REG_FB_W_CTRL:     fb_w_ctrl_q     <= acc.wdata;
				REG_FB_R_SIZE:     fb_r_size_q     <= acc.wdata;
				REG_FB_W_SOF1:     fb_w_sof1_q     <= acc.wdata;
				REG_FPU_PARAM_CFG: fpu_param_cfg_q <= acc.wdata;
				REG_ISP_BACKGND_D: isp_backgnd_d_q <= acc.wdata;
				REG_SPG_CONTROL:   spg_control_q   <= acc.wdata;
				REG_VO_CONTROL:    vo_control_q    <= acc.wdata;
				REG_TA_ISP_BASE:   ta_isp_base_q   <= acc.wdata;
				REG_TA_ALLOC_CTRL: ta_alloc_ctrl_q <= acc.wdata;
				default: ;                              // id, revision, unmapped: dropped
			endcase
		end
	end

	always_comb begin
		case (acc.sel)
			REG_ID:            rdata_o = PVR_ID_VALUE;
			REG_REVISION:      rdata_o = PVR_REVISION_VALUE;
			REG_SOFTRESET:     rdata_o = softreset_q;
			REG_STARTRENDER:   rdata_o = startrender_q;
			REG_PARAM_BASE:    rdata_o = param_base_q;
			REG_REGION_BASE:   rdata_o = region_base_q;
			REG_FB_R_CTRL:     rdata_o = fb_r_ctrl_q;
			REG_FB_W_CTRL:     rdata_o = fb_w_ctrl_q;
			REG_FB_R_SIZE:     rdata_o = fb_r_size_q;
			REG_FB_W_SOF1:     rdata_o = fb_w_sof1_q;
			REG_FPU_PARAM_CFG: rdata_o = fpu_param_cfg_q;
			REG_ISP_BACKGND_D: rdata_o = isp_backgnd_d_q;
			REG_SPG_CONTROL:   rdata_o = spg_control_q;
			REG_VO_CONTROL:    rdata_o = vo_control_q;
			REG_TA_ISP_BASE:   rdata_o = ta_isp_base_q;
			REG_TA_ALLOC_CTRL: rdata_o = ta_alloc_ctrl_q;
			default:           rdata_o = '0;            // unmapped reads zero
		endcase
	end

	// config words go straight out to the render side
	assign param_base_o    = param_base_q;
	assign region_base_o   = region_base_q;
	assign fpu_param_cfg_o = fpu_param_cfg_q;
	assign ta_alloc_ctrl_o = ta_alloc_ctrl_q;

endmodule

//--- logic/pvr_regs.sv
`timescale 1ns/1ps

module pvr_regs
	import pvr_pkg::*;
#(
	parameter int PAL_ADDR_W = 10                       // palette index width
) (
	input  logic       clock,
	input  logic       reset_n,
	input  logic       pvr_reg_cs_i,                    // register space select
	input  host_addr_t pvr_addr_i,
	input  reg_word_t  pvr_din_i,
	input  logic       pvr_rd_i,
	input  logic       pvr_wr_i,
	output reg_word_t  pvr_dout_o,                      // valid the cycle after a read
	output reg_word_t  param_base_o,
	output reg_word_t  region_base_o,
	output reg_word_t  fpu_param_cfg_o,
	output reg_word_t  ta_alloc_ctrl_o
);

	reg_word_t reg_rdata;                               // bank -> read mux
	reg_word_t pal_rdata;                               // palette -> read mux

	reg_access_if #(
		.PAL_ADDR_W (PAL_ADDR_W)
	) u_acc ();

	pvr_addr_decode #(
		.PAL_ADDR_W (PAL_ADDR_W)
	) u_addr_decode (
		.reg_cs_i (pvr_reg_cs_i),
		.addr_i   (pvr_addr_i),
		.din_i    (pvr_din_i),
		.rd_i     (pvr_rd_i),
		.wr_i     (pvr_wr_i),
		.acc      (u_acc.decode)
	);

	pvr_reg_bank u_reg_bank (
		.clock           (clock),
		.reset_n         (reset_n),
		.acc             (u_acc.bank),
		.rdata_o         (reg_rdata),
		.param_base_o    (param_base_o),
		.region_base_o   (region_base_o),
		.fpu_param_cfg_o (fpu_param_cfg_o),
		.ta_alloc_ctrl_o (ta_alloc_ctrl_o)
	);

	pvr_palette_ram #(
		.PAL_ADDR_W (PAL_ADDR_W)
	) u_palette_ram (
		.clock   (clock),
		.acc     (u_acc.palette),
		.rdata_o (pal_rdata)
	);

	pvr_read_mux u_read_mux (
		.clock       (clock),
		.reset_n     (reset_n),
		.acc         (u_acc.result),
		.reg_rdata_i (reg_rdata),
		.pal_rdata_i (pal_rdata),
		.dout_o      (pvr_dout_o)
	);

endmodule

//--- logic/reg_access_if.sv
`timescale 1ns/1ps

interface reg_access_if
	import pvr_pkg::*;
#(
	parameter int PAL_ADDR_W = 10                       // palette index width
) ();

	logic                  wr_en;                       // chip-selected write, one cycle
	logic                  rd_en;                       // chip-selected read, one cycle
	reg_sel_e              sel;                         // decoded register
	logic                  pal_hit;                     // address inside palette window
	logic [PAL_ADDR_W-1:0] pal_index;                   // palette word index
	reg_word_t             wdata;                       // host write word

	modport decode (output wr_en, rd_en, sel, pal_hit, pal_index, wdata);
	modport bank (input wr_en, sel, wdata);
	modport palette (input wr_en, rd_en, pal_hit, pal_index, wdata);
	modport result (input rd_en, pal_hit);

endinterface
